// File: dv/ex_stage_assert.sv
// Execute stage handshake assertions
`timescale 1ns/10ps

module ex_stage_assert import ex_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      alu_en_i,
  input logic      mul_en_i,
  input logic      kill_i,
  input logic      halt_i,
  input logic      wb_ready_i,
  input logic      ex_valid_i,
  input logic      wb_valid_i,
  input logic      wb_rf_we_i,
  input reg_addr_t wb_rf_waddr_i,
  input word_t     wb_rf_wdata_i,
  input logic      wb_bch_taken_i
);

  // Assertion failure count
  int fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////////////////////////

  // Kill and halt suppress the stage result
  valid_blocked: assert property (
    @(posedge clk) disable iff (!rst_n) (kill_i || halt_i) |-> !ex_valid_i
  ) else begin
    fail_cnt++;
    $error("ex_valid_o high while kill_i or halt_i is set");
  end

  // EX/WB register frozen under back-pressure
  wb_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable({wb_valid_i, wb_rf_we_i, wb_rf_waddr_i, wb_rf_wdata_i,
                             wb_bch_taken_i})
  ) else begin
    fail_cnt++;
    $error("wb outputs changed while wb_ready_i was low");
  end

  // One functional unit per instruction
  one_unit: assert property (
    @(posedge clk) disable iff (!rst_n) !(alu_en_i && mul_en_i)
  ) else begin
    fail_cnt++;
    $error("alu_en_i and mul_en_i both set");
  end

  // First cycle out of reset
  wb_idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !wb_valid_i
  ) else begin
    fail_cnt++;
    $error("wb_valid_o high in the first cycle after reset");
  end

endmodule

bind ex_stage ex_stage_assert u_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .alu_en_i       (alu_en_i),
  .mul_en_i       (mul_en_i),
  .kill_i         (kill_i),
  .halt_i         (halt_i),
  .wb_ready_i     (wb_ready_i),
  .ex_valid_i     (ex_valid_o),
  .wb_valid_i     (wb_valid_o),
  .wb_rf_we_i     (wb_rf_we_o),
  .wb_rf_waddr_i  (wb_rf_waddr_o),
  .wb_rf_wdata_i  (wb_rf_wdata_o),
  .wb_bch_taken_i (wb_bch_taken_o)
);

// File: dv/ex_stage_tb.sv
// Execute stage testbench
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_stage_tb import ex_pkg::*; ();

  localparam logic [31:0] SEED = 32'h1f3b4934;
  // About twice the length of 1200 instructions at up to 8 cycles each
  localparam int MAX_CYCLES = 20000;
  localparam int MUL_LAT    = `MUL_STEPS + 1;

  // Instruction kinds
  localparam int K_ALU = 0;
  localparam int K_BCH = 1;
  localparam int K_MUL = 2;
  localparam int K_NOP = 3;

  // Expected EX/WB register contents
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    logic      taken;
  } wb_entry_t;

  logic      clk;
  logic      rst_n;
  logic      id_valid_i;
  logic      alu_en_i;
  logic      mul_en_i;
  logic      alu_bch_i;
  logic      rf_we_i;
  reg_addr_t rf_waddr_i;
  alu_op_e   alu_operator_i;
  mul_op_e   mul_operator_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  word_t     operand_c_i;
  logic      kill_i;
  logic      halt_i;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      ex_valid_o;
  word_t     rf_wdata_o;
  logic      branch_decision_o;
  word_t     branch_target_o;
  logic      wb_valid_o;
  logic      wb_rf_we_o;
  reg_addr_t wb_rf_waddr_o;
  word_t     wb_rf_wdata_o;
  logic      wb_bch_taken_o;

  wb_entry_t exp_q[$];
  wb_entry_t exp_ent;
  int        n_checks  = 0;
  int        n_errors  = 0;
  int        n_instr   = 0;
  int        err_mark  = 0;
  int        cycle_cnt = 0;
  int        lat_cnt   = 0;
  bit        lat_check = 1'b0;

  ex_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic cmp_ref(alu_op_e op, word_t a, word_t b);
    case (op)
      EQ:        return a == b;
      NE:        return a != b;
      LT, SLT:   return $signed(a) < $signed(b);
      GE:        return $signed(a) >= $signed(b);
      LTU, SLTU: return a < b;
      GEU:       return a >= b;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
    logic [2*`XLEN-1:0] wide;
    wide = '0;
    case (op)
      ADD:       wide = {32'b0, a} + {32'b0, b};
      SUB:       wide = {32'b0, a} - {32'b0, b};
      SLL:       wide = {32'b0, a} << b[4:0];
      SRL:       wide = {32'b0, a} >> b[4:0];
      // Sign copies in the upper word shift down into the result
      SRA:       wide = {{32{a[31]}}, a} >> b[4:0];
      AND:       wide = {32'b0, a & b};
      OR:        wide = {32'b0, a | b};
      XOR:       wide = {32'b0, a ^ b};
      SLT, SLTU: wide = {63'b0, cmp_ref(op, a, b)};
      default:   wide = '0;
    endcase
    return wide[`XLEN-1:0];
  endfunction

  function automatic word_t mul_ref(mul_op_e op, word_t a, word_t b);
    logic [2*`XLEN-1:0] ea;
    logic [2*`XLEN-1:0] eb;
    logic [2*`XLEN-1:0] prod;
    ea   = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    eb   = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ea * eb;
    return (op == MUL) ? prod[31:0] : prod[63:32];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t got, input word_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    n_checks++;
    assert (ok) else begin
      n_errors++;
      $display("failure at t=%0t: %s", $time, what);
    end
  endtask

  // Monitor samples at the rising edge before the DUT registers update
  always @(posedge clk) begin
    if (rst_n) begin
      // Write-back takes the EX/WB register contents
      if (wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          check_cond(1'b0, "write-back valid with no instruction pending");
        end else begin
          exp_ent = exp_q.pop_front();
          check_value("wb_rf_we_o", word_t'(wb_rf_we_o), word_t'(exp_ent.we));
          if (exp_ent.we) begin
            check_value("wb_rf_waddr_o", word_t'(wb_rf_waddr_o), word_t'(exp_ent.waddr));
            check_value("wb_rf_wdata_o", wb_rf_wdata_o, exp_ent.wdata);
          end
          check_value("wb_bch_taken_o", word_t'(wb_bch_taken_o), word_t'(exp_ent.taken));
        end
      end
      if (halt_i && !kill_i) begin
        check_cond(!ex_ready_o, "ex_ready_o high while halt_i is set");
      end
      // Branch outputs in the presentation cycle
      if (id_valid_i && alu_en_i && (alu_operator_i >= SLT)) begin
        check_value("branch_decision_o", word_t'(branch_decision_o),
                    word_t'(cmp_ref(alu_operator_i, operand_a_i, operand_b_i)));
        check_value("branch_target_o", branch_target_o, operand_c_i);
      end
      if (id_valid_i && alu_en_i && !kill_i && !halt_i) begin
        check_cond(ex_valid_o, "ex_valid_o low for a live ALU instruction");
      end
      // Multiply latency in edges since presentation
      if (id_valid_i && mul_en_i && !kill_i && !halt_i) begin
        if (ex_valid_o) begin
          if (lat_check) begin
            check_value("ex_valid_o latency", word_t'(lat_cnt), word_t'(MUL_LAT));
          end
          lat_cnt = 0;
        end else begin
          lat_cnt++;
        end
      end else begin
        lat_cnt = 0;
      end
      // Accepted live instruction goes to the expected queue
      if (id_valid_i && ex_ready_o && !kill_i && !halt_i && (alu_en_i || mul_en_i)) begin
        exp_ent.we    = rf_we_i;
        exp_ent.waddr = rf_waddr_i;
        exp_ent.wdata = mul_en_i ? mul_ref(mul_operator_i, operand_a_i, operand_b_i) :
                                   alu_ref(alu_operator_i, operand_a_i, operand_b_i);
        exp_ent.taken = alu_bch_i && alu_en_i &&
                        cmp_ref(alu_operator_i, operand_a_i, operand_b_i);
        exp_q.push_back(exp_ent);
        // Forwarded result of a value-producing instruction
        if (mul_en_i || (alu_operator_i < EQ)) begin
          check_value("rf_wdata_o", rf_wdata_o, exp_ent.wdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Edge values help the compares hit equal and sign cases
  function automatic word_t rand_word();
    case ($urandom_range(5))
      0:       return word_t'($urandom_range(31));
      1:       return 32'h8000_0000;
      2:       return 32'hffff_ffff;
      default: return $urandom();
    endcase
  endfunction

  task automatic drive_idle(input bit bp);
    @(negedge clk);
    id_valid_i = 1'b0;
    alu_en_i   = 1'b0;
    mul_en_i   = 1'b0;
    alu_bch_i  = 1'b0;
    rf_we_i    = 1'b0;
    kill_i     = 1'b0;
    halt_i     = 1'b0;
    wb_ready_i = bp ? ($urandom_range(3) != 0) : 1'b1;
  endtask

  // Present one instruction and hold it until the stage accepts it
  // kill_at counts edges before kill_i rises and -1 means never
  task automatic issue_instr(input int kind, input bit bp, input int kill_at,
                             input int halt_cycles);
    bit accepted;
    int edges;
    @(negedge clk);
    id_valid_i     = 1'b1;
    alu_en_i       = (kind == K_ALU) || (kind == K_BCH);
    mul_en_i       = (kind == K_MUL);
    alu_bch_i      = (kind == K_BCH) && ($urandom_range(7) != 0);
    rf_we_i        = (kind != K_BCH) && ($urandom_range(3) != 0);
    rf_waddr_i     = reg_addr_t'($urandom_range(31));
    alu_operator_i = (kind == K_BCH) ? alu_op_e'($urandom_range(15, 10)) :
                                       alu_op_e'($urandom_range(9));
    mul_operator_i = mul_op_e'($urandom_range(3));
    operand_a_i    = rand_word();
    operand_b_i    = ($urandom_range(3) == 0) ? operand_a_i : rand_word();
    operand_c_i    = $urandom();
    kill_i         = (kill_at == 0);
    halt_i         = (halt_cycles > 0);
    wb_ready_i     = bp ? ($urandom_range(3) != 0) : 1'b1;
    edges    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = ex_ready_o;
      edges++;
      if (!accepted) begin
        @(negedge clk);
        kill_i = (edges == kill_at);
        halt_i = (edges < halt_cycles);
        if (bp) begin
          wb_ready_i = ($urandom_range(3) != 0);
        end
      end
    end
    n_instr++;
  endtask

  // Let the last result reach write-back
  task automatic drain_wb();
    int guard;
    drive_idle(1'b0);
    guard = 0;
    while (exp_q.size() != 0 && guard < 10) begin
      @(negedge clk);
      guard++;
    end
    check_cond(exp_q.size() == 0, "expected write-back never arrived");
    exp_q.delete();
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d instructions, %0d errors", name, n_instr, n_errors - err_mark);
    n_instr  = 0;
    err_mark = n_errors;
  endtask

  initial begin
    int scen;
    int total_errors;
    void'($urandom(SEED));
    rst_n          = 1'b0;
    id_valid_i     = 1'b0;
    alu_en_i       = 1'b0;
    mul_en_i       = 1'b0;
    alu_bch_i      = 1'b0;
    rf_we_i        = 1'b0;
    rf_waddr_i     = '0;
    alu_operator_i = ADD;
    mul_operator_i = MUL;
    operand_a_i    = '0;
    operand_b_i    = '0;
    operand_c_i    = '0;
    kill_i         = 1'b0;
    halt_i         = 1'b0;
    wb_ready_i     = 1'b1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Reset values before any stimulus
    check_value("wb_valid_o", word_t'(wb_valid_o), '0);
    check_value("ex_valid_o", word_t'(ex_valid_o), '0);
    check_value("wb_bch_taken_o", word_t'(wb_bch_taken_o), '0);
    check_value("wb_rf_waddr_o", word_t'(wb_rf_waddr_o), '0);
    check_value("wb_rf_wdata_o", wb_rf_wdata_o, '0);
    end_test("reset");

    repeat (400) issue_instr(K_ALU, 1'b0, -1, 0);
    drain_wb();
    end_test("alu");

    repeat (200) issue_instr(K_BCH, 1'b0, -1, 0);
    drain_wb();
    end_test("branch");

    lat_check = 1'b1;
    repeat (200) issue_instr(K_MUL, 1'b0, -1, 0);
    drain_wb();
    lat_check = 1'b0;
    end_test("multiply");

    // Mixed traffic with random write-back stalls and bubbles
    repeat (300) begin
      issue_instr($urandom_range(K_NOP), 1'b1, -1, 0);
      if ($urandom_range(3) == 0) begin
        drive_idle(1'b1);
      end
    end
    drain_wb();
    end_test("back-pressure");

    repeat (100) begin
      scen = $urandom_range(3);
      case (scen)
        0:       issue_instr(($urandom_range(1) != 0) ? K_MUL : K_ALU, 1'b0, 0, 0);
        1:       issue_instr(K_MUL, 1'b0, $urandom_range(`MUL_STEPS + 1, 1), 0);
        2:       issue_instr($urandom_range(K_MUL), 1'b0, -1, $urandom_range(4, 1));
        default: issue_instr(K_MUL, 1'b0, -1, 0);
      endcase
    end
    drain_wb();
    end_test("kill-halt");

    total_errors = n_errors + dut.u_assert.fail_cnt;
    $display("summary: %0d checks, %0d check errors, %0d assertion failures",
             n_checks, n_errors, dut.u_assert.fail_cnt);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_wb_pipe.sv
verilog/ex_stage.sv
dv/ex_stage_assert.sv
dv/ex_stage_tb.sv

// File: verilog/ex_alu.sv
// Single-cycle ALU
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_o
);

  // Shared adder
  logic             adder_sub;
  word_t            adder_b;
  logic [`XLEN:0]   adder_sum;

  // Compare flags
  logic             is_equal;
  logic             is_lt;
  logic             is_ltu;
  logic             cmp_result;

  // Shifter
  logic             shift_left;
  word_t            shift_in;
  logic [`XLEN:0]   shift_ext;
  logic [`XLEN:0]   shift_out;
  word_t            shift_result;

  //////////////////////////////////////////////////////////////////////
  // Adder and compare
  //////////////////////////////////////////////////////////////////////

  // Everything except ADD subtracts, compares reuse the difference
  assign adder_sub = (operator_i != ADD);
  assign adder_b   = adder_sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{`XLEN{1'b0}}, adder_sub};

  assign is_equal = (adder_sum[`XLEN-1:0] == '0);
  // No carry out of a - b means a borrow
  assign is_ltu   = !adder_sum[`XLEN];
  // Signs differ: a is smaller exactly when it is negative
  assign is_lt    = (operand_a_i[`XLEN-1] != operand_b_i[`XLEN-1]) ?
                    operand_a_i[`XLEN-1] : adder_sum[`XLEN-1];

  always_comb begin
    case (operator_i)
      EQ:          cmp_result = is_equal;
      NE:          cmp_result = !is_equal;
      LT, SLT:     cmp_result = is_lt;
      GE:          cmp_result = !is_lt;
      LTU, SLTU:   cmp_result = is_ltu;
      GEU:         cmp_result = !is_ltu;
      default:     cmp_result = 1'b0;
    endcase
  end

  assign cmp_o = cmp_result;

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  // Left shifts run through the right shifter on the bit-reversed operand
  assign shift_left   = (operator_i == SLL);
  assign shift_in     = shift_left ? {<<{operand_a_i}} : operand_a_i;
  // Extra top bit carries the sign for SRA only
  assign shift_ext    = {(operator_i == SRA) & operand_a_i[`XLEN-1], shift_in};
  assign shift_out    = $signed(shift_ext) >>> operand_b_i[$clog2(`XLEN)-1:0];
  assign shift_result = shift_left ? {<<{shift_out[`XLEN-1:0]}} : shift_out[`XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ADD, SUB:       result_o = adder_sum[`XLEN-1:0];
      SLL, SRL, SRA:  result_o = shift_result;
      AND:            result_o = operand_a_i & operand_b_i;
      OR:             result_o = operand_a_i | operand_b_i;
      XOR:            result_o = operand_a_i ^ operand_b_i;
      // Set-less-than writes the compare bit
      SLT, SLTU:      result_o = {{(`XLEN-1){1'b0}}, cmp_result};
      default:        result_o = '0;
    endcase
  end

endmodule

// File: verilog/ex_macros.svh
// Execute stage constants
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data word width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

//////////////////////////////////////////////////////////////////////
// Multiplier
//////////////////////////////////////////////////////////////////////

// Partial product cycles spent in CALC
`define MUL_STEPS 4

`endif

// File: verilog/ex_mult.sv
// Iterative multiplier
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_mult import ex_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  mul_op_e operator_i,
  input  word_t   op_a_i,
  input  word_t   op_b_i,
  input  logic    valid_i,
  input  logic    ready_i,
  output logic    ready_o,
  output logic    valid_o,
  output word_t   result_o
);

  mul_state_e                     state_q;
  mul_state_e                     state_d;
  logic [$clog2(`MUL_STEPS)-1:0]  step_q;
  logic                           last_step;

  // Operands extended to 34 bits, split into two 17-bit halves
  logic                           a_signed;
  logic                           b_signed;
  logic [33:0]                    a_ext;
  logic [33:0]                    b_ext;
  logic [17:0]                    a_part;
  logic [17:0]                    b_part;
  logic signed [35:0]             pp;
  logic [5:0]                     pp_shift;
  logic [65:0]                    pp_ext;
  logic [65:0]                    acc_q;

  assign a_signed = (operator_i == MULH) || (operator_i == MULHSU);
  assign b_signed = (operator_i == MULH);
  assign a_ext    = {{2{a_signed & op_a_i[`XLEN-1]}}, op_a_i};
  assign b_ext    = {{2{b_signed & op_b_i[`XLEN-1]}}, op_b_i};

  // Step bit 1 picks the A half, bit 0 the B half
  // Upper halves are signed, lower halves unsigned
  assign a_part   = step_q[1] ? {a_ext[33], a_ext[33:17]} : {1'b0, a_ext[16:0]};
  assign b_part   = step_q[0] ? {b_ext[33], b_ext[33:17]} : {1'b0, b_ext[16:0]};
  assign pp       = $signed(a_part) * $signed(b_part);
  assign pp_shift = (step_q[1] && step_q[0]) ? 6'd34 :
                    (step_q[1] || step_q[0]) ? 6'd17 : 6'd0;
  assign pp_ext   = {{30{pp[35]}}, pp} << pp_shift;

  assign last_step = (int'(step_q) == `MUL_STEPS - 1);

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ready_o = 1'b0;
    valid_o = 1'b0;
    case (state_q)
      IDLE: begin
        ready_o = !valid_i;
        if (valid_i) begin
          state_d = CALC;
        end
      end
      CALC: begin
        // Dropped enable means kill or halt
        if (!valid_i) begin
          state_d = IDLE;
        end else if (last_step) begin
          state_d = DONE;
        end
      end
      DONE: begin
        valid_o = 1'b1;
        ready_o = ready_i;
        // Result held until write-back takes it
        if (!valid_i || ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      step_q  <= (state_q == CALC) ? step_q + 1'b1 : '0;
    end
  end

  // Accumulator, cleared while idle
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      acc_q <= '0;
    end else if (state_q == CALC) begin
      acc_q <= acc_q + pp_ext;
    end
  end

  assign result_o = (operator_i == MUL) ? acc_q[31:0] : acc_q[63:32];

endmodule

// File: verilog/ex_pkg.sv
// Execute stage types
package ex_pkg;

`include "ex_macros.svh"

  // Operand, result and branch target word
  typedef logic [`XLEN-1:0] word_t;

  // Destination register index
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations
  // The last six are branch compares
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SRL,
    SRA,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiplier operations, low product and the three high variants
  typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mul_op_e;

  // Multiplier sequencing
  typedef enum logic [1:0] {IDLE, CALC, DONE} mul_state_e;

endpackage

// File: verilog/ex_stage.sv
// Execute stage top
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // From decode
  input  logic      id_valid_i,
  input  logic      alu_en_i,
  input  logic      mul_en_i,
  input  logic      alu_bch_i,
  input  logic      rf_we_i,
  input  reg_addr_t rf_waddr_i,
  input  alu_op_e   alu_operator_i,
  input  mul_op_e   mul_operator_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     operand_c_i,

  // From controller
  input  logic      kill_i,
  input  logic      halt_i,

  // Handshake with decode and write-back
  input  logic      wb_ready_i,
  output logic      ex_ready_o,
  output logic      ex_valid_o,

  // Forwarding to decode
  output word_t     rf_wdata_o,

  // To fetch
  output logic      branch_decision_o,
  output word_t     branch_target_o,

  // EX/WB register outputs
  output logic      wb_valid_o,
  output logic      wb_rf_we_o,
  output reg_addr_t wb_rf_waddr_o,
  output word_t     wb_rf_wdata_o,
  output logic      wb_bch_taken_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mul_result;
  logic  mul_valid;
  logic  mul_ready;
  logic  mul_en_gated;

  // Branch outcome straight from the ALU compare
  assign branch_decision_o = alu_cmp;
  assign branch_target_o   = operand_c_i;

  ex_alu u_alu (
    .operator_i  (alu_operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .result_o   (mul_result)
  );

  ex_wb_pipe u_wb_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid_i     (id_valid_i),
    .alu_en_i       (alu_en_i),
    .mul_en_i       (mul_en_i),
    .alu_bch_i      (alu_bch_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .wb_ready_i     (wb_ready_i),
    .alu_result_i   (alu_result),
    .alu_cmp_i      (alu_cmp),
    .mul_result_i   (mul_result),
    .mul_valid_i    (mul_valid),
    .mul_ready_i    (mul_ready),
    .mul_en_gated_o (mul_en_gated),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o),
    .rf_wdata_o     (rf_wdata_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

// File: verilog/ex_wb_pipe.sv
// EX stage handshake and EX/WB register
`timescale 1ns/10ps

module ex_wb_pipe import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      id_valid_i,
  input  logic      alu_en_i,
  input  logic      mul_en_i,
  input  logic      alu_bch_i,
  input  logic      rf_we_i,
  input  reg_addr_t rf_waddr_i,
  input  logic      kill_i,
  input  logic      halt_i,
  input  logic      wb_ready_i,
  input  word_t     alu_result_i,
  input  logic      alu_cmp_i,
  input  word_t     mul_result_i,
  input  logic      mul_valid_i,
  input  logic      mul_ready_i,
  output logic      mul_en_gated_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  output word_t     rf_wdata_o,
  output logic      wb_valid_o,
  output logic      wb_rf_we_o,
  output reg_addr_t wb_rf_waddr_o,
  output word_t     wb_rf_wdata_o,
  output logic      wb_bch_taken_o
);

  logic instr_valid;
  logic alu_ready;

  // Live instruction, suppressed by kill and halt
  assign instr_valid    = id_valid_i && !kill_i && !halt_i;
  assign mul_en_gated_o = mul_en_i && instr_valid;

  // ALU ready follows write-back
  assign alu_ready = wb_ready_i;

  // Kill frees the stage right away
  assign ex_ready_o = kill_i || (alu_ready && mul_ready_i && !halt_i);
  // ALU result is valid in the same cycle
  assign ex_valid_o = (alu_en_i || (mul_en_i && mul_valid_i)) && instr_valid;

  // Forwarded to decode
  assign rf_wdata_o = mul_en_i ? mul_result_i : alu_result_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_rf_waddr_o  <= '0;
      wb_rf_wdata_o  <= '0;
      wb_bch_taken_o <= 1'b0;
    end else begin
      if (ex_valid_o && wb_ready_i) begin
        wb_valid_o     <= 1'b1;
        wb_rf_we_o     <= rf_we_i;
        // Address and data only move for a register write
        if (rf_we_i) begin
          wb_rf_waddr_o <= rf_waddr_i;
          wb_rf_wdata_o <= rf_wdata_o;
        end
        wb_bch_taken_o <= alu_bch_i && alu_en_i && alu_cmp_i;
      end else if (wb_ready_i) begin
        // Bubble when there is nothing to hand over
        wb_valid_o <= 1'b0;
      end
    end
  end

endmodule
